//--- branch_pred_top.f
+incdir+hw
hw/corep.sv
hw/bram_2rport_1wport.sv
hw/flush_sweep_counter.sv
hw/gbpt_flush_fsm.sv
hw/gbpt.sv
hw/branch_pred_top.sv
verification/tb_branch_pred_top.sv

//--- hw/bram_2rport_1wport.sv
`default_nettype none

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 8,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                           CLK,
    input  logic                           nRST,

    // read port 0
    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    // read port 1
    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    // byte-enabled write port
    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    localparam int BYTES = INNER_WIDTH / 8;

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // reads see the word before a same-cycle write
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
            for (int b = 0; b < BYTES; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/branch_pred_top.sv
`default_nettype none

module branch_pred_top (
    input  logic                  CLK,
    input  logic                  nRST,

    input  corep::ASID_t          arch_asid,

    input  corep::gbpt_read_req_t read_req,
    input  corep::gbpt_update_t   update,
    input  logic                  flush_req,

    output corep::lane_taken_t    read_resp_taken_by_lane,
    output logic                  flush_busy
);

    // ------------------------------------------------------------------------
    // flush control wires

    logic             sweep_en;
    logic             sweep_last;
    logic             flush_active;
    corep::GBPT_idx_t sweep_index;

    // ------------------------------------------------------------------------
    // instances

    gbpt_flush_fsm u_flush_fsm (
        .CLK(CLK),
        .nRST(nRST),
        .flush_req(flush_req),
        .sweep_last(sweep_last),
        .sweep_en(sweep_en),
        .flush_active(flush_active),
        .flush_busy(flush_busy)
    );

    // one set per cycle while sweeping
    flush_sweep_counter u_sweep_counter (
        .CLK(CLK),
        .nRST(nRST),
        .sweep_en(sweep_en),
        .sweep_index(sweep_index),
        .sweep_last(sweep_last)
    );

    gbpt u_gbpt (
        .CLK(CLK),
        .nRST(nRST),
        .arch_asid(arch_asid),
        .read_req(read_req),
        .read_resp_taken_by_lane(read_resp_taken_by_lane),
        .update(update),
        .flush_active(flush_active),
        .flush_index(sweep_index)
    );

endmodule

`default_nettype wire

//--- hw/corep.sv
`default_nettype none

`include "corep_defines.svh"

package corep;

    // ------------------------------------------------------------------------
    // widths and basic types

    localparam int GBPT_IDX_BITS = $clog2(`GBPT_SETS);

    typedef logic [GBPT_IDX_BITS-1:0]                 GBPT_idx_t;
    typedef logic [GBPT_IDX_BITS-1:0]                 GH_t;
    typedef logic [GBPT_IDX_BITS-1:0]                 ASID_t;
    typedef logic [`PC_BITS-`LOG_FETCH_LANES-1:0]     fetch_idx_t;
    typedef logic [`PC_BITS-1:0]                      PC38_t;
    typedef logic [`LOG_FETCH_LANES-1:0]              fetch_lane_t;

    // two-bit counter as {taken, strong}, weakly-not-taken is the cleared value
    typedef enum logic [1:0] {
        TBC_WN = 2'b00,
        TBC_SN = 2'b01,
        TBC_WT = 2'b10,
        TBC_ST = 2'b11
    } tbc_t;

    typedef tbc_t [`FETCH_LANES-1:0]  GBPT_set_t;
    typedef logic [`FETCH_LANES-1:0]  lane_taken_t;

    typedef struct packed {
        logic       valid;
        fetch_idx_t fetch_index;
        GH_t        gh;
    } gbpt_read_req_t;

    typedef struct packed {
        logic  valid;
        PC38_t pc;
        GH_t   gh;
        logic  taken;
    } gbpt_update_t;

    typedef enum logic [1:0] {
        FLUSH_IDLE  = 2'b00,
        FLUSH_SWEEP = 2'b01,
        FLUSH_DONE  = 2'b10
    } flush_state_t;

    // ------------------------------------------------------------------------
    // helper functions

    // low fetch index bits folded with history and asid
    function automatic GBPT_idx_t index_hash(fetch_idx_t fetch_index, GH_t gh, ASID_t asid);
        return fetch_index[GBPT_IDX_BITS-1:0] ^ gh ^ asid;
    endfunction

    function automatic tbc_t tbc_updater(tbc_t last_state, logic taken);
        tbc_t next_state;
        case (last_state)
            TBC_WN:  next_state = taken ? TBC_ST : TBC_SN;
            TBC_SN:  next_state = taken ? TBC_WN : TBC_SN;
            TBC_WT:  next_state = taken ? TBC_ST : TBC_SN;
            TBC_ST:  next_state = taken ? TBC_ST : TBC_WT;
            default: next_state = TBC_WN;
        endcase
        return next_state;
    endfunction

    function automatic fetch_lane_t fetch_lane_bits(PC38_t pc);
        return pc[`LOG_FETCH_LANES-1:0];
    endfunction

endpackage

`default_nettype wire

//--- hw/corep_defines.svh
`ifndef COREP_DEFINES_SVH
`define COREP_DEFINES_SVH

// ------------------------------------------------------------------------
// fetch block geometry

// branch lanes per fetch block
`define FETCH_LANES 4

// log2 of the lane count, low PC bits that pick the lane
`define LOG_FETCH_LANES 2

// ------------------------------------------------------------------------
// prediction table sizing

// number of sets in the global branch prediction table
`define GBPT_SETS 64

// width of a branch PC as seen by the update path
`define PC_BITS 38

`endif

//--- hw/flush_sweep_counter.sv
`default_nettype none

`include "corep_defines.svh"

module flush_sweep_counter (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             sweep_en,
    output corep::GBPT_idx_t sweep_index,
    output logic             sweep_last
);

    localparam corep::GBPT_idx_t LAST_SET = corep::GBPT_idx_t'(`GBPT_SETS - 1);

    assign sweep_last = (sweep_index == LAST_SET);

    // parked at set 0 between sweeps
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sweep_index <= '0;
        end else if (sweep_en) begin
            if (sweep_last) begin
                sweep_index <= '0;
            end else begin
                sweep_index <= sweep_index + 1'b1;
            end
        end else begin
            sweep_index <= '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/gbpt.sv
`default_nettype none

`include "corep_defines.svh"

module gbpt (
    input  logic                  CLK,
    input  logic                  nRST,

    input  corep::ASID_t          arch_asid,

    // fetch read, response one cycle later
    input  corep::gbpt_read_req_t read_req,
    output corep::lane_taken_t    read_resp_taken_by_lane,

    // resolved branch update
    input  corep::gbpt_update_t   update,

    // flush write from the sweep
    input  logic                  flush_active,
    input  corep::GBPT_idx_t      flush_index
);

    localparam int SET_BITS  = $bits(corep::GBPT_set_t);
    localparam int SET_BYTES = SET_BITS / 8;

    // ------------------------------------------------------------------------
    // memory port signals

    logic                   rd0_en;
    corep::GBPT_idx_t       rd0_index;
    logic [SET_BITS-1:0]    rd0_data;
    corep::GBPT_set_t       rd0_set;

    logic                   rd1_en;
    corep::GBPT_idx_t       rd1_index;
    logic [SET_BITS-1:0]    rd1_data;
    corep::GBPT_set_t       rd1_set;

    logic [SET_BYTES-1:0]   write_byten;
    corep::GBPT_idx_t       write_index;
    corep::GBPT_set_t       write_set;

    // write stage
    logic                   write_flush;
    corep::fetch_lane_t     write_lane;
    logic                   write_taken;

    // ------------------------------------------------------------------------
    // read path

    assign rd0_en    = read_req.valid;
    assign rd0_index = corep::index_hash(read_req.fetch_index, read_req.gh, arch_asid);
    assign rd0_set   = corep::GBPT_set_t'(rd0_data);

    // taken is the upper counter bit
    always_comb begin
        for (int lane = 0; lane < `FETCH_LANES; lane++) begin
            read_resp_taken_by_lane[lane] = rd0_set[lane] inside {corep::TBC_WT, corep::TBC_ST};
        end
    end

    // ------------------------------------------------------------------------
    // update and flush write stage

    // updates are dropped while the sweep owns the write port
    assign rd1_en    = update.valid && !flush_active;
    assign rd1_index = corep::index_hash(update.pc[`PC_BITS-1:`LOG_FETCH_LANES],
                                         update.gh, arch_asid);
    assign rd1_set   = corep::GBPT_set_t'(rd1_data);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            write_byten <= '0;
            write_flush <= 1'b0;
        end else begin
            write_byten <= {SET_BYTES{flush_active || update.valid}};
            write_flush <= flush_active;
        end
    end

    always_ff @(posedge CLK) begin
        write_index <= flush_active ? flush_index : rd1_index;
        write_lane  <= corep::fetch_lane_bits(update.pc);
        write_taken <= update.taken;
    end

    // only the addressed lane moves on an update
    always_comb begin
        write_set = rd1_set;
        write_set[write_lane] = corep::tbc_updater(rd1_set[write_lane], write_taken);
        if (write_flush) begin
            for (int lane = 0; lane < `FETCH_LANES; lane++) begin
                write_set[lane] = corep::TBC_WN;
            end
        end
    end

    // ------------------------------------------------------------------------
    // table storage

    bram_2rport_1wport #(
        .INNER_WIDTH(SET_BITS),
        .OUTER_WIDTH(`GBPT_SETS)
    ) u_gbpt_array (
        .CLK(CLK),
        .nRST(nRST),
        .port0_ren(rd0_en),
        .port0_rindex(rd0_index),
        .port0_rdata(rd0_data),
        .port1_ren(rd1_en),
        .port1_rindex(rd1_index),
        .port1_rdata(rd1_data),
        .wen_byte(write_byten),
        .windex(write_index),
        .wdata(write_set)
    );

endmodule

`default_nettype wire

//--- hw/gbpt_flush_fsm.sv
`default_nettype none

module gbpt_flush_fsm (
    input  logic CLK,
    input  logic nRST,
    input  logic flush_req,
    input  logic sweep_last,
    output logic sweep_en,
    output logic flush_active,
    output logic flush_busy
);

    corep::flush_state_t state;
    corep::flush_state_t next_state;

    // ------------------------------------------------------------------------
    // state register

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= corep::FLUSH_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------------
    // next state

    // requests outside idle are ignored
    always_comb begin
        next_state = state;
        case (state)
            corep::FLUSH_IDLE: begin
                if (flush_req) begin
                    next_state = corep::FLUSH_SWEEP;
                end
            end
            corep::FLUSH_SWEEP: begin
                if (sweep_last) begin
                    next_state = corep::FLUSH_DONE;
                end
            end
            // last registered write lands here
            corep::FLUSH_DONE: begin
                next_state = corep::FLUSH_IDLE;
            end
            default: begin
                next_state = corep::FLUSH_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // outputs

    assign sweep_en     = (state == corep::FLUSH_SWEEP);
    assign flush_active = (state == corep::FLUSH_SWEEP);
    assign flush_busy   = (state != corep::FLUSH_IDLE);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f branch_pred_top.f \
    --top-module tb_branch_pred_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verification/tb_branch_pred_top.sv
`default_nettype none

`include "corep_defines.svh"

module tb_branch_pred_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES   = 10;
    localparam int FLUSH_CYCLES   = `GBPT_SETS + 1;
    localparam int RANDOM_CYCLES  = 1500;
    // reset, reads, directed, random, two flush windows, asid and drain
    localparam int TEST_CYCLES    = RESET_CYCLES + 40 + 30 + RANDOM_CYCLES
                                    + 2 * FLUSH_CYCLES + 220 + 30;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                  CLK;
    logic                  nRST;
    corep::ASID_t          arch_asid;
    corep::gbpt_read_req_t read_req;
    corep::gbpt_update_t   update;
    logic                  flush_req;
    corep::lane_taken_t    read_resp_taken_by_lane;
    logic                  flush_busy;

    // ------------------------------------------------------------------------
    // reference model state

    corep::GBPT_set_t      shadow [`GBPT_SETS];
    corep::GBPT_set_t      pend_set;
    corep::GBPT_idx_t      pend_idx;
    logic                  pend_valid;
    int                    busy_left;
    corep::lane_taken_t    exp_q [$];
    corep::lane_taken_t    exp_taken;

    // inputs that the next rising edge samples
    corep::gbpt_read_req_t cur_rd;
    corep::gbpt_update_t   cur_upd;
    logic                  cur_flush;
    corep::ASID_t          cur_asid;
    corep::ASID_t          next_asid;

    logic [16:0]           lfsr_state;
    corep::PC38_t          pc_pool [8];
    string                 test_name;
    int                    errors;
    int                    cycles;
    int                    busy_run;

    branch_pred_top u_branch_pred_top (
        .CLK(CLK),
        .nRST(nRST),
        .arch_asid(arch_asid),
        .read_req(read_req),
        .update(update),
        .flush_req(flush_req),
        .read_resp_taken_by_lane(read_resp_taken_by_lane),
        .flush_busy(flush_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("run timed out after %0d cycles with %0d errors", cycles, errors);
        $display("Result: FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // random numbers and reference functions

    // taps 17 14, one step per bit
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic corep::GBPT_idx_t ref_index(corep::fetch_idx_t f, corep::GH_t gh,
                                                   corep::ASID_t asid);
        return f[5:0] ^ gh ^ asid;
    endfunction

    function automatic corep::tbc_t ref_next(corep::tbc_t s, logic taken);
        case (s)
            corep::TBC_WN: return taken ? corep::TBC_ST : corep::TBC_SN;
            corep::TBC_SN: return taken ? corep::TBC_WN : corep::TBC_SN;
            corep::TBC_WT: return taken ? corep::TBC_ST : corep::TBC_SN;
            default:       return taken ? corep::TBC_ST : corep::TBC_WT;
        endcase
    endfunction

    function automatic corep::lane_taken_t expected_taken(corep::fetch_idx_t f, corep::GH_t gh,
                                                          corep::ASID_t asid);
        corep::GBPT_set_t   entry;
        corep::lane_taken_t v;
        entry = shadow[ref_index(f, gh, asid)];
        for (int l = 0; l < `FETCH_LANES; l++) begin
            v[l] = (entry[l] == corep::TBC_WT) || (entry[l] == corep::TBC_ST);
        end
        return v;
    endfunction

    function automatic corep::gbpt_read_req_t make_read(logic v, corep::fetch_idx_t f,
                                                        corep::GH_t gh);
        corep::gbpt_read_req_t r;
        r.valid       = v;
        r.fetch_index = f;
        r.gh          = gh;
        return r;
    endfunction

    function automatic corep::gbpt_update_t make_update(logic v, corep::PC38_t pc,
                                                       corep::GH_t gh, logic taken);
        corep::gbpt_update_t u;
        u.valid = v;
        u.pc    = pc;
        u.gh    = gh;
        u.taken = taken;
        return u;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks

    task automatic check_taken(string name, corep::lane_taken_t exp, corep::lane_taken_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_busy(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("Error %s busy expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_length(string name, int exp, int act);
        if (exp != act) begin
            errors++;
            $display("Error %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // model step and stimulus

    // order follows the table: reads see the old set, then the write lands
    task automatic model_edge();
        corep::GBPT_idx_t    idx;
        corep::fetch_lane_t  lane;
        if (cur_rd.valid) begin
            exp_q.push_back(expected_taken(cur_rd.fetch_index, cur_rd.gh, cur_asid));
        end
        if (pend_valid) begin
            shadow[pend_idx] = pend_set;
        end
        pend_valid = 1'b0;
        if (busy_left > 0) begin
            busy_left--;
        end
        if (cur_flush && busy_left == 0) begin
            busy_left = FLUSH_CYCLES;
            for (int s = 0; s < `GBPT_SETS; s++) begin
                shadow[s] = '0;
            end
        end
        if (cur_upd.valid && busy_left == 0) begin
            idx  = ref_index(cur_upd.pc[`PC_BITS-1:`LOG_FETCH_LANES], cur_upd.gh, cur_asid);
            lane = cur_upd.pc[`LOG_FETCH_LANES-1:0];
            pend_set       = shadow[idx];
            pend_set[lane] = ref_next(pend_set[lane], cur_upd.taken);
            pend_idx       = idx;
            pend_valid     = 1'b1;
        end
    endtask

    task automatic apply_cycle(corep::gbpt_read_req_t r, corep::gbpt_update_t u, logic f);
        @(posedge CLK);
        model_edge();
        read_req  <= r;
        update    <= u;
        flush_req <= f;
        arch_asid <= next_asid;
        cur_rd    = r;
        cur_upd   = u;
        cur_flush = f;
        cur_asid  = next_asid;
    endtask

    task automatic idle_cycle();
        apply_cycle(make_read(1'b0, '0, '0), make_update(1'b0, '0, '0, 1'b0), 1'b0);
    endtask

    task automatic read_cycle(corep::fetch_idx_t f, corep::GH_t gh);
        apply_cycle(make_read(1'b1, f, gh), make_update(1'b0, '0, '0, 1'b0), 1'b0);
    endtask

    task automatic update_cycle(corep::PC38_t pc, corep::GH_t gh, logic taken);
        apply_cycle(make_read(1'b0, '0, '0), make_update(1'b1, pc, gh, taken), 1'b0);
    endtask

    // responses and busy checked mid-cycle, away from the driving edge
    always @(negedge CLK) begin
        if (nRST) begin
            if (exp_q.size() > 0) begin
                exp_taken = exp_q.pop_front();
                check_taken(test_name, exp_taken, read_resp_taken_by_lane);
            end
            check_busy(test_name, busy_left > 0, flush_busy);
            if (flush_busy) begin
                busy_run++;
            end else if (busy_run > 0) begin
                check_length("flush busy cycles", FLUSH_CYCLES, busy_run);
                busy_run = 0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // test sequence

    initial begin
        int                  i;
        corep::PC38_t        pc;
        corep::GH_t          gh;
        corep::gbpt_update_t u;
        corep::GBPT_idx_t    uidx;
        corep::GBPT_idx_t    last_idx;
        logic                last_v;

        nRST       = 1'b0;
        read_req   = '0;
        update     = '0;
        flush_req  = 1'b0;
        arch_asid  = '0;
        cur_rd     = '0;
        cur_upd    = '0;
        cur_flush  = 1'b0;
        cur_asid   = '0;
        next_asid  = '0;
        pend_valid = 1'b0;
        busy_left  = 0;
        busy_run   = 0;
        errors     = 0;
        lfsr_state = 17'd95525;
        test_name  = "reset reads";
        for (int s = 0; s < `GBPT_SETS; s++) begin
            shadow[s] = '0;
        end
        for (int p = 0; p < 8; p++) begin
            pc_pool[p] = corep::PC38_t'(lfsr_bits(38));
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        for (i = 0; i < 40; i++) begin
            next_asid = corep::ASID_t'(lfsr_bits(6));
            read_cycle(corep::fetch_idx_t'(lfsr_bits(36)), corep::GH_t'(lfsr_bits(6)));
        end

        // WN -> ST -> WT -> SN on one lane
        test_name = "counter rule";
        pc = pc_pool[0];
        gh = corep::GH_t'(lfsr_bits(6));
        update_cycle(pc, gh, 1'b1);
        idle_cycle();
        read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], gh);
        update_cycle(pc, gh, 1'b0);
        idle_cycle();
        read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], gh);
        update_cycle(pc, gh, 1'b0);
        idle_cycle();
        read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], gh);
        idle_cycle();

        test_name = "random traffic";
        last_v   = 1'b0;
        last_idx = '0;
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            pc   = pc_pool[int'(lfsr_bits(3))];
            gh   = corep::GH_t'(lfsr_bits(2));
            u    = make_update(1'(lfsr_bits(1)), pc_pool[int'(lfsr_bits(3))],
                               corep::GH_t'(lfsr_bits(2)), 1'(lfsr_bits(1)));
            uidx = ref_index(u.pc[`PC_BITS-1:`LOG_FETCH_LANES], u.gh, next_asid);
            // same set needs two cycles between updates
            if (u.valid && last_v && uidx == last_idx) begin
                u.valid = 1'b0;
            end
            last_v   = u.valid;
            last_idx = uidx;
            apply_cycle(make_read(1'(lfsr_bits(1)), pc[`PC_BITS-1:`LOG_FETCH_LANES], gh),
                        u, 1'b0);
        end
        idle_cycle();

        // a dropped update and an ignored second request inside the sweep
        test_name = "flush";
        apply_cycle(make_read(1'b0, '0, '0), make_update(1'b0, '0, '0, 1'b0), 1'b1);
        i = 0;
        do begin
            i++;
            if (i == `GBPT_SETS) begin
                // on the last sweep cycle an accepted write would outlive the sweep
                update_cycle(pc_pool[1], '0, 1'b1);
            end else if (i == 30) begin
                apply_cycle(make_read(1'b0, '0, '0), make_update(1'b0, '0, '0, 1'b0), 1'b1);
            end else begin
                idle_cycle();
            end
            @(negedge CLK);
        end while (flush_busy);

        test_name = "reads after flush";
        for (i = 0; i < 150; i++) begin
            pc = pc_pool[int'(lfsr_bits(3))];
            read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], corep::GH_t'(lfsr_bits(2)));
        end

        test_name = "asid change";
        next_asid = 6'h0a;
        pc = pc_pool[2];
        update_cycle(pc, '0, 1'b1);
        idle_cycle();
        read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], '0);
        next_asid = 6'h0a ^ 6'h15;
        read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], '0);
        next_asid = 6'h0a;
        read_cycle(pc[`PC_BITS-1:`LOG_FETCH_LANES], '0);
        repeat (4) idle_cycle();
        @(negedge CLK);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
